// File: verilog.f
verilog/apu_pkg.sv
verilog/apu_issue.sv
verilog/apu_fp_misc.sv
verilog/apu_int_mul.sv
verilog/apu_result_merge.sv
verilog/apu_top.sv
sim/tb_apu.sv

// File: Makefile
# Verilator build and run of the APU subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_apu
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "no result line in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_apu.sv
/*
 * Testbench for the APU subsystem
 * Directed tests of the FP misc unit, the multiplier and the issue rules
 */
module tb_apu
    import apu_pkg::*;
();

    localparam int MUL_BPC   = 2;
    localparam int GNT_LIMIT = 64;
    localparam int MAX_IDS   = 256;
    // Upper bound on operations issued over all tests
    localparam int NUM_OPS   = 180;
    // Each operation costs at most one full multiply plus issue and response
    localparam int WATCHDOG_CYCLES = NUM_OPS * (32 / MUL_BPC + 4) + 500;

    logic                clk;
    logic                rst_n;
    logic                apu_req;
    apu_op_e             apu_op;
    logic [APU_WORD-1:0] apu_operand_a;
    logic [APU_WORD-1:0] apu_operand_b;
    logic                apu_gnt;
    logic                apu_rvalid;
    logic [APU_WORD-1:0] apu_rdata;
    apu_flags_t          apu_rflags;

    int cycle       = 0;
    int next_id     = 0;
    int err_count   = 0;
    int check_count = 0;
    int test_count  = 0;
    int test_err_start;
    logic [31:0] lcg_state;

    // Expected responses, keyed by operation id in grant order
    int                  exp_id_q [$];
    logic [APU_WORD-1:0] exp_data   [MAX_IDS];
    apu_flags_t          exp_flags  [MAX_IDS];
    int                  grant_edge [MAX_IDS];
    int                  rsp_edge   [MAX_IDS];

    apu_top #(
        .MUL_BITS_PER_CYCLE (MUL_BPC)
    ) DUT (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .apu_req_i       (apu_req),
        .apu_op_i        (apu_op),
        .apu_operand_a_i (apu_operand_a),
        .apu_operand_b_i (apu_operand_b),
        .apu_gnt_o       (apu_gnt),
        .apu_rvalid_o    (apu_rvalid),
        .apu_rdata_o     (apu_rdata),
        .apu_rflags_o    (apu_rflags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic fp_is_nan(fp32_u w);
        return w.raw[30:0] > 31'h7F80_0000;
    endfunction

    function automatic logic fp_is_snan(fp32_u w);
        return fp_is_nan(w) && !w.f.man[22];
    endfunction

    // Signed ordering key of a non-NaN value where -0 and +0 share one key
    function automatic int fp_key(fp32_u w);
        int k;
        k = int'(w.raw[30:0]);
        return w.f.sign ? -k : k;
    endfunction

    // True when a lies strictly below b and -0 counts below +0 as min and max require
    function automatic logic fp_below(fp32_u a, fp32_u b);
        return (fp_key(a) < fp_key(b)) ||
               (fp_key(a) == fp_key(b) && a.f.sign && !b.f.sign);
    endfunction

    function automatic logic [9:0] fclass_mask(fp32_u w);
        logic [30:0] mag;
        int          pos;
        mag = w.raw[30:0];
        if (mag > 31'h7F80_0000) pos = w.f.man[22] ? 9 : 8;
        else if (mag == 31'h7F80_0000) pos = w.f.sign ? 0 : 7;
        else if (mag >= 31'h0080_0000) pos = w.f.sign ? 1 : 6;
        else if (mag != 31'd0) pos = w.f.sign ? 2 : 5;
        else pos = w.f.sign ? 3 : 4;
        return 10'd1 << pos;
    endfunction

    function automatic logic [31:0] ref_data(apu_op_e op, fp32_u a, fp32_u b);
        logic [63:0]        pu;
        logic signed [63:0] ps;
        fp32_u              r;
        pu = {32'd0, a.raw} * {32'd0, b.raw};
        ps = $signed({{32{a.raw[31]}}, a.raw}) * $signed({{32{b.raw[31]}}, b.raw});
        r  = a;
        case (op)
            FMIN, FMAX: begin
                if (fp_is_nan(a) && fp_is_nan(b)) return 32'h7FC0_0000;
                if (fp_is_nan(a)) return b.raw;
                if (fp_is_nan(b)) return a.raw;
                if (op == FMIN) return fp_below(b, a) ? b.raw : a.raw;
                return fp_below(a, b) ? b.raw : a.raw;
            end
            FSGNJ:  r.f.sign = b.f.sign;
            FSGNJN: r.f.sign = !b.f.sign;
            FSGNJX: r.f.sign = a.f.sign ^ b.f.sign;
            FEQ:    return 32'(!fp_is_nan(a) && !fp_is_nan(b) && fp_key(a) == fp_key(b));
            FLT:    return 32'(!fp_is_nan(a) && !fp_is_nan(b) && fp_key(a) < fp_key(b));
            FLE:    return 32'(!fp_is_nan(a) && !fp_is_nan(b) && fp_key(a) <= fp_key(b));
            FCLASS: return {22'd0, fclass_mask(a)};
            MUL:    return pu[31:0];
            MULH:   return ps[63:32];
            MULHU:  return pu[63:32];
            default: return '0;
        endcase
        return r.raw;
    endfunction

    function automatic apu_flags_t ref_flags(apu_op_e op, fp32_u a, fp32_u b);
        apu_flags_t f;
        f = '0;
        if (op inside {FMIN, FMAX, FEQ}) f.nv = fp_is_snan(a) || fp_is_snan(b);
        if (op inside {FLT, FLE}) f.nv = fp_is_nan(a) || fp_is_nan(b);
        return f;
    endfunction

    task automatic check_word(input string name, input logic [APU_WORD-1:0] got,
                              input logic [APU_WORD-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flags(input string name, input apu_flags_t got,
                               input apu_flags_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_gap(input string what, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            err_count++;
            $display("%s was %0d cycles, expected %0d", what, got, exp);
        end
    endtask

    // Response data is stable at the falling edge
    always @(negedge clk) begin : monitor
        int rid;
        if (rst_n && apu_rvalid) begin
            if (exp_id_q.size() == 0) begin
                err_count++;
                $display("rvalid pulse at cycle %0d with no operation pending", cycle);
            end else begin
                rid = exp_id_q.pop_front();
                rsp_edge[rid] = cycle + 1;
                check_word("apu_rdata_o", apu_rdata, exp_data[rid]);
                check_flags("apu_rflags_o", apu_rflags, exp_flags[rid]);
            end
        end
    end

    // Starts 1 time unit after a rising edge and returns 1 time unit after the grant edge
    task automatic issue_op(input apu_op_e op, input logic [APU_WORD-1:0] a,
                            input logic [APU_WORD-1:0] b, output int id);
        int waited;
        id = next_id;
        next_id++;
        exp_data[id]  = ref_data(op, a, b);
        exp_flags[id] = ref_flags(op, a, b);
        exp_id_q.push_back(id);
        apu_req       = 1'b1;
        apu_op        = op;
        apu_operand_a = a;
        apu_operand_b = b;
        waited        = 0;
        #1;
        while (!apu_gnt && waited < GNT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!apu_gnt) begin
            err_count++;
            $display("no grant for %s within %0d cycles", op.name(), GNT_LIMIT);
            void'(exp_id_q.pop_back());
            apu_req = 1'b0;
        end
        @(posedge clk);
        #1;
        grant_edge[id] = cycle;
    endtask

    task automatic release_req();
        apu_req = 1'b0;
    endtask

    task automatic drain();
        while (exp_id_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %-12s %0d errors", name, err_count - test_err_start);
    endtask

    task automatic test_reset();
        repeat (5) begin
            @(negedge clk);
            check_bit("apu_gnt_o", apu_gnt, 1'b0);
            check_bit("apu_rvalid_o", apu_rvalid, 1'b0);
            check_word("apu_rdata_o", apu_rdata, '0);
            check_flags("apu_rflags_o", apu_rflags, '0);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_sign_class();
        logic [31:0] mags [3] = '{32'h3F80_0000, 32'hC020_0000, 32'h7F80_0000};
        logic [31:0] signs [2] = '{32'h0000_0000, 32'h8000_0000};
        apu_op_e     sj_ops [3] = '{FSGNJ, FSGNJN, FSGNJX};
        // -inf, -norm, -sub, -0, +0, +sub, +norm, +inf, sNaN, qNaN
        logic [31:0] cls [10] = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0010,
                                  32'h8000_0000, 32'h0000_0000, 32'h0000_0010,
                                  32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001,
                                  32'h7FC0_0000};
        int id;
        foreach (mags[i]) begin
            foreach (signs[j]) begin
                foreach (sj_ops[k]) begin
                    issue_op(sj_ops[k], mags[i], signs[j], id);
                end
            end
        end
        foreach (cls[i]) begin
            issue_op(FCLASS, cls[i], 32'd0, id);
        end
        release_req();
        drain();
    endtask

    task automatic test_minmax_cmp();
        logic [31:0] pa [11] = '{32'h0000_0000, 32'h8000_0000, 32'h3F80_0000,
                                 32'h7FC0_0000, 32'h3F80_0000, 32'h7FC0_0000,
                                 32'h7F80_0001, 32'h7F80_0000, 32'h0000_0001,
                                 32'hC020_0000, 32'h3F80_0000};
        logic [31:0] pb [11] = '{32'h8000_0000, 32'h0000_0000, 32'hBF80_0000,
                                 32'h3F80_0000, 32'h7F80_0001, 32'h7FC0_0000,
                                 32'hFFC0_0000, 32'hC020_0000, 32'h0000_0000,
                                 32'hBF80_0000, 32'h3F80_0000};
        apu_op_e     ops [5] = '{FMIN, FMAX, FEQ, FLT, FLE};
        int id;
        foreach (pa[i]) begin
            foreach (ops[k]) begin
                issue_op(ops[k], pa[i], pb[i], id);
            end
        end
        release_req();
        drain();
    endtask

    task automatic test_multiply();
        logic [31:0] ca [5] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000,
                                32'h7FFF_FFFF, 32'h0000_0000};
        logic [31:0] cb [5] = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000,
                                32'h8000_0000, 32'h1234_5678};
        apu_op_e     ops [3] = '{MUL, MULH, MULHU};
        logic [31:0] a;
        logic [31:0] b;
        int id;
        repeat (20) begin
            a = lcg_next();
            b = lcg_next();
            foreach (ops[k]) begin
                issue_op(ops[k], a, b, id);
            end
        end
        foreach (ca[i]) begin
            foreach (ops[k]) begin
                issue_op(ops[k], ca[i], cb[i], id);
            end
        end
        release_req();
        drain();
    endtask

    task automatic test_fp_stream();
        int ids [8];
        int id;
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 8; i++) begin
            a = lcg_next();
            b = lcg_next();
            issue_op(apu_op_e'(i % 9), a, b, ids[i]);
        end
        release_req();
        drain();
        for (int i = 1; i < 8; i++) begin
            expect_gap("grant spacing in FP stream", grant_edge[ids[i]] - grant_edge[ids[0]], i);
            expect_gap("response spacing in FP stream", rsp_edge[ids[i]] - rsp_edge[ids[0]], i);
        end
        issue_op(FMAX, 32'h4049_0FDB, 32'hC000_0000, id);
        release_req();
        drain();
        expect_gap("lone FP response latency", rsp_edge[id] - grant_edge[id], 3);
    endtask

    task automatic test_mixed();
        int id_mul;
        int id_fp;
        int id_fp2;
        int id_fp3;
        int id_mul2;
        issue_op(MULH, 32'hFFFF_FFF6, 32'h0000_0007, id_mul);
        // Held off until the multiplier reports its result
        issue_op(FSGNJN, 32'h4049_0FDB, 32'h0000_0000, id_fp);
        expect_gap("FP grant after multiply grant",
                   grant_edge[id_fp] - grant_edge[id_mul], 32 / MUL_BPC + 1);
        issue_op(FLT, 32'hBF80_0000, 32'h3F80_0000, id_fp2);
        issue_op(FMIN, 32'h7FC0_0000, 32'h4000_0000, id_fp3);
        issue_op(MULHU, 32'hDEAD_BEEF, 32'h0000_1000, id_mul2);
        expect_gap("multiply grant after last FP grant",
                   grant_edge[id_mul2] - grant_edge[id_fp3], 3);
        release_req();
        drain();
        expect_gap("multiply response latency",
                   rsp_edge[id_mul] - grant_edge[id_mul], 32 / MUL_BPC + 2);
        expect_gap("second multiply response latency",
                   rsp_edge[id_mul2] - grant_edge[id_mul2], 32 / MUL_BPC + 2);
    endtask

    initial begin
        lcg_state     = 32'ha78d;
        rst_n         = 1'b0;
        apu_req       = 1'b0;
        apu_op        = FMIN;
        apu_operand_a = '0;
        apu_operand_b = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_err_start = err_count;
        test_reset();
        end_test("reset");
        test_err_start = err_count;
        test_sign_class();
        end_test("sign_class");
        test_err_start = err_count;
        test_minmax_cmp();
        end_test("minmax_cmp");
        test_err_start = err_count;
        test_multiply();
        end_test("multiply");
        test_err_start = err_count;
        test_fp_stream();
        end_test("fp_stream");
        test_err_start = err_count;
        test_mixed();
        end_test("mixed");

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/apu_top.sv
/*
 * APU subsystem top level
 * Issue stage, FP misc unit, integer multiplier and result stage
 */
module apu_top
    import apu_pkg::*;
#(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Request side
    input  logic                apu_req_i,
    input  apu_op_e             apu_op_i,
    input  logic [APU_WORD-1:0] apu_operand_a_i,
    input  logic [APU_WORD-1:0] apu_operand_b_i,
    output logic                apu_gnt_o,

    // Response side
    output logic                apu_rvalid_o,
    output logic [APU_WORD-1:0] apu_rdata_o,
    output apu_flags_t          apu_rflags_o
);

    logic                fp_start, mul_start;
    logic                fp_busy, mul_busy;
    logic                fp_valid, mul_valid;
    logic [APU_WORD-1:0] fp_result, mul_result;
    apu_flags_t          fp_flags;

    apu_issue u_issue (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .apu_req_i   (apu_req_i),
        .apu_op_i    (apu_op_i),
        .fp_busy_i   (fp_busy),
        .mul_busy_i  (mul_busy),
        .apu_gnt_o   (apu_gnt_o),
        .fp_start_o  (fp_start),
        .mul_start_o (mul_start)
    );

    apu_fp_misc u_fp_misc (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (fp_start),
        .op_i        (apu_op_i),
        .operand_a_i (apu_operand_a_i),
        .operand_b_i (apu_operand_b_i),
        .valid_o     (fp_valid),
        .busy_o      (fp_busy),
        .result_o    (fp_result),
        .flags_o     (fp_flags)
    );

    apu_int_mul #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_int_mul (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (mul_start),
        .op_i        (apu_op_i),
        .operand_a_i (apu_operand_a_i),
        .operand_b_i (apu_operand_b_i),
        .valid_o     (mul_valid),
        .busy_o      (mul_busy),
        .result_o    (mul_result)
    );

    apu_result_merge u_merge (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fp_valid_i   (fp_valid),
        .fp_result_i  (fp_result),
        .fp_flags_i   (fp_flags),
        .mul_valid_i  (mul_valid),
        .mul_result_i (mul_result),
        .apu_rvalid_o (apu_rvalid_o),
        .apu_rdata_o  (apu_rdata_o),
        .apu_rflags_o (apu_rflags_o)
    );

endmodule

// File: verilog/apu_result_merge.sv
/*
 * APU result stage
 * Registers the result of the unit that finishes onto the response port
 */
module apu_result_merge
    import apu_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                fp_valid_i,
    input  logic [APU_WORD-1:0] fp_result_i,
    input  apu_flags_t          fp_flags_i,

    input  logic                mul_valid_i,
    input  logic [APU_WORD-1:0] mul_result_i,

    output logic                apu_rvalid_o,
    output logic [APU_WORD-1:0] apu_rdata_o,
    output apu_flags_t          apu_rflags_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            apu_rvalid_o <= 1'b0;
        end else begin
            apu_rvalid_o <= fp_valid_i || mul_valid_i;
        end
    end

    // Response data holds its last value between pulses
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            apu_rdata_o  <= '0;
            apu_rflags_o <= '0;
        end else if (fp_valid_i) begin
            apu_rdata_o  <= fp_result_i;
            apu_rflags_o <= fp_flags_i;
        end else if (mul_valid_i) begin
            apu_rdata_o  <= mul_result_i;
            // Integer products raise no FP exceptions
            apu_rflags_o <= '0;
        end
    end

    // The issue rule keeps the two units from finishing together
    a_single_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(fp_valid_i && mul_valid_i)
    );

endmodule

// File: verilog/apu_int_mul.sv
/*
 * Iterative integer multiplier
 * Shift-add over MUL_BITS_PER_CYCLE multiplier bits per cycle,
 * returning the low or high word of the 64-bit product
 */
module apu_int_mul
    import apu_pkg::*;
#(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                start_i,
    input  apu_op_e             op_i,
    input  logic [APU_WORD-1:0] operand_a_i,
    input  logic [APU_WORD-1:0] operand_b_i,

    output logic                valid_o,
    output logic                busy_o,
    output logic [APU_WORD-1:0] result_o
);

    localparam int STEPS = APU_WORD / MUL_BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic [CNT_W-1:0]      count_q;
    logic [2*APU_WORD-1:0] acc_q, acc_d;
    logic [2*APU_WORD-1:0] mcand_q;
    logic [APU_WORD-1:0]   mplier_q;
    logic                  neg_q;
    logic                  hi_q;

    logic                  is_signed;
    logic [APU_WORD-1:0]   a_mag, b_mag;
    logic [2*APU_WORD-1:0] product;

    // Only MULH treats the operands as signed
    assign is_signed = (op_i == MULH);
    assign a_mag = (is_signed && operand_a_i[APU_WORD-1]) ? -operand_a_i : operand_a_i;
    assign b_mag = (is_signed && operand_b_i[APU_WORD-1]) ? -operand_b_i : operand_b_i;

    // Partial products for the low multiplier bits of this step
    always_comb begin
        acc_d = acc_q;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (mplier_q[i]) begin
                acc_d = acc_d + (mcand_q << i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_o  <= 1'b0;
            valid_o <= 1'b0;
            count_q <= '0;
        end else begin
            valid_o <= 1'b0;
            if (start_i) begin
                busy_o  <= 1'b1;
                count_q <= CNT_W'(STEPS);
            end else if (busy_o) begin
                count_q <= count_q - 1'b1;
                if (count_q == CNT_W'(1)) begin
                    busy_o  <= 1'b0;
                    valid_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc_q    <= '0;
            mcand_q  <= {{APU_WORD{1'b0}}, a_mag};
            mplier_q <= b_mag;
            neg_q    <= is_signed && (operand_a_i[APU_WORD-1] ^ operand_b_i[APU_WORD-1]);
            hi_q     <= (op_i != MUL);
        end else if (busy_o) begin
            acc_q    <= acc_d;
            mcand_q  <= mcand_q << MUL_BITS_PER_CYCLE;
            mplier_q <= mplier_q >> MUL_BITS_PER_CYCLE;
        end
    end

    // Sign fix-up of the magnitude product
    assign product  = neg_q ? -acc_q : acc_q;
    assign result_o = hi_q ? product[2*APU_WORD-1:APU_WORD] : product[APU_WORD-1:0];

    // Issue must hold off new multiplies until this one has retired
    a_no_start_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> !busy_o
    );

endmodule

// File: verilog/apu_fp_misc.sv
/*
 * Single-precision non-arithmetic unit
 * Two stages: operand capture with classification, then min/max,
 * sign injection, compare and classify
 */
module apu_fp_misc
    import apu_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                start_i,
    input  apu_op_e             op_i,
    input  logic [APU_WORD-1:0] operand_a_i,
    input  logic [APU_WORD-1:0] operand_b_i,

    output logic                valid_o,
    output logic                busy_o,
    output logic [APU_WORD-1:0] result_o,
    output apu_flags_t          flags_o
);

    // Bit positions of the RISC-V fclass mask
    localparam int CLS_NINF  = 0;
    localparam int CLS_NNORM = 1;
    localparam int CLS_NSUB  = 2;
    localparam int CLS_NZERO = 3;
    localparam int CLS_PZERO = 4;
    localparam int CLS_PSUB  = 5;
    localparam int CLS_PNORM = 6;
    localparam int CLS_PINF  = 7;
    localparam int CLS_SNAN  = 8;
    localparam int CLS_QNAN  = 9;

    localparam logic [APU_WORD-1:0] CANON_NAN = 32'h7FC0_0000;

    function automatic logic [9:0] fp_class(fp32_u w);
        logic       exp_max;
        logic       exp_zero;
        logic       man_zero;
        logic [9:0] m;
        exp_max  = &w.f.exp;
        exp_zero = ~|w.f.exp;
        man_zero = ~|w.f.man;
        m        = '0;
        if (exp_max && !man_zero) begin
            // Quiet bit is the top of the mantissa
            if (w.f.man[22]) m[CLS_QNAN] = 1'b1;
            else m[CLS_SNAN] = 1'b1;
        end else if (exp_max) begin
            m[w.f.sign ? CLS_NINF : CLS_PINF] = 1'b1;
        end else if (exp_zero && man_zero) begin
            m[w.f.sign ? CLS_NZERO : CLS_PZERO] = 1'b1;
        end else if (exp_zero) begin
            m[w.f.sign ? CLS_NSUB : CLS_PSUB] = 1'b1;
        end else begin
            m[w.f.sign ? CLS_NNORM : CLS_PNORM] = 1'b1;
        end
        return m;
    endfunction

    fp32_u      in_w   [APU_NARGS];
    logic [9:0] in_cls [APU_NARGS];

    // Stage 1 registers
    logic       s1_valid;
    apu_op_e    s1_op;
    fp32_u      s1_opnd [APU_NARGS];
    logic [9:0] s1_cls  [APU_NARGS];

    // Stage 2 next-state
    logic [APU_WORD-1:0] res_d;
    apu_flags_t          flags_d;

    fp32_u a, b;
    logic  a_nan, b_nan, any_snan, both_zero;
    logic  a_lt, a_eq;

    assign in_w[0] = operand_a_i;
    assign in_w[1] = operand_b_i;

    always_comb begin
        for (int i = 0; i < APU_NARGS; i++) begin
            in_cls[i] = fp_class(in_w[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= start_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            s1_op <= op_i;
            for (int i = 0; i < APU_NARGS; i++) begin
                s1_opnd[i] <= in_w[i];
                s1_cls[i]  <= in_cls[i];
            end
        end
    end

    assign a = s1_opnd[0];
    assign b = s1_opnd[1];

    assign a_nan     = s1_cls[0][CLS_SNAN] || s1_cls[0][CLS_QNAN];
    assign b_nan     = s1_cls[1][CLS_SNAN] || s1_cls[1][CLS_QNAN];
    assign any_snan  = s1_cls[0][CLS_SNAN] || s1_cls[1][CLS_SNAN];
    assign both_zero = (s1_cls[0][CLS_NZERO] || s1_cls[0][CLS_PZERO]) &&
                       (s1_cls[1][CLS_NZERO] || s1_cls[1][CLS_PZERO]);

    // Ordering by sign-magnitude, -0 sits below +0
    always_comb begin
        if (a.f.sign != b.f.sign) begin
            a_lt = a.f.sign;
        end else if (a.f.sign) begin
            a_lt = a.raw[30:0] > b.raw[30:0];
        end else begin
            a_lt = a.raw[30:0] < b.raw[30:0];
        end
    end

    assign a_eq = (a.raw == b.raw) || both_zero;

    always_comb begin
        res_d   = '0;
        flags_d = '0;
        case (s1_op)
            FMIN, FMAX: begin
                flags_d.nv = any_snan;
                if (a_nan && b_nan) res_d = CANON_NAN;
                else if (a_nan) res_d = b.raw;
                else if (b_nan) res_d = a.raw;
                else if ((s1_op == FMIN) == a_lt) res_d = a.raw;
                else res_d = b.raw;
            end
            FSGNJ:  res_d = {b.f.sign, a.raw[30:0]};
            FSGNJN: res_d = {~b.f.sign, a.raw[30:0]};
            FSGNJX: res_d = {a.f.sign ^ b.f.sign, a.raw[30:0]};
            FEQ: begin
                flags_d.nv = any_snan;
                res_d[0]   = !a_nan && !b_nan && a_eq;
            end
            FLT: begin
                flags_d.nv = a_nan || b_nan;
                res_d[0]   = !a_nan && !b_nan && a_lt && !both_zero;
            end
            FLE: begin
                flags_d.nv = a_nan || b_nan;
                res_d[0]   = !a_nan && !b_nan && (a_lt || a_eq);
            end
            FCLASS: res_d = {22'd0, s1_cls[0]};
            default: res_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid) begin
            result_o <= res_d;
            flags_o  <= flags_d;
        end
    end

    assign busy_o = s1_valid || valid_o;

endmodule

// File: verilog/apu_issue.sv
/*
 * APU issue stage
 * Decodes the requested operation, grants it under the in-order rule
 * and strobes the start of the selected execution unit
 */
module apu_issue
    import apu_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    input  logic    apu_req_i,
    input  apu_op_e apu_op_i,

    input  logic    fp_busy_i,
    input  logic    mul_busy_i,

    output logic    apu_gnt_o,
    output logic    fp_start_o,
    output logic    mul_start_o
);

    logic is_fp;
    logic unit_free;

    assign is_fp = (apu_unit_of(apu_op_i) == UNIT_FP);

    // FP work may overlap other FP work, but never a running multiply.
    // A multiply needs both units idle so results stay in grant order
    always_comb begin
        if (is_fp) begin
            unit_free = !mul_busy_i;
        end else begin
            unit_free = !fp_busy_i && !mul_busy_i;
        end
    end

    assign apu_gnt_o = apu_req_i && unit_free;

    // One strobe per accepted operation
    assign fp_start_o  = apu_gnt_o && is_fp;
    assign mul_start_o = apu_gnt_o && !is_fp;

    // A stalled request stays up with the same operation until granted
    a_req_held: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        apu_req_i && !apu_gnt_o |=> apu_req_i && $stable(apu_op_i)
    );

endmodule

// File: verilog/apu_pkg.sv
/*
 * APU shared definitions
 * Operation codes, the float word view, result flags and unit selection
 */
package apu_pkg;

    localparam int APU_NARGS = 2;
    localparam int APU_WORD  = 32;

    typedef enum logic [3:0] {
        FMIN   = 4'd0,
        FMAX   = 4'd1,
        FSGNJ  = 4'd2,
        FSGNJN = 4'd3,
        FSGNJX = 4'd4,
        FEQ    = 4'd5,
        FLT    = 4'd6,
        FLE    = 4'd7,
        FCLASS = 4'd8,
        MUL    = 4'd9,
        MULH   = 4'd10,
        MULHU  = 4'd11
    } apu_op_e;

    // Single-precision word, raw or split into IEEE 754 fields
    typedef union packed {
        logic [APU_WORD-1:0] raw;
        struct packed {
            logic        sign;
            logic [7:0]  exp;
            logic [22:0] man;
        } f;
    } fp32_u;

    // Same bit order as the RISC-V fflags CSR
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } apu_flags_t;

    typedef enum logic {
        UNIT_FP  = 1'b0,
        UNIT_MUL = 1'b1
    } apu_unit_e;

    function automatic apu_unit_e apu_unit_of(apu_op_e op);
        return (op inside {MUL, MULH, MULHU}) ? UNIT_MUL : UNIT_FP;
    endfunction

endpackage
